// ==== rtl/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

////////////////////////////////////////
// Datapath and register file sizes
////////////////////////////////////////

`define MIPS_XLEN 32
`define MIPS_NREGS 32
`define MIPS_REG_AW 5

// Return address register for JAL
`define MIPS_LINK_REG 31

`endif

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

	`include "mips_settings.svh"

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, // R-type, decoded by funct
		OP_J = 6'b000010,
		OP_JAL = 6'b000011,
		OP_BEQ = 6'b000100,
		OP_BNE = 6'b000101,
		OP_ADDI = 6'b001000,
		OP_SLTI = 6'b001010,
		OP_ANDI = 6'b001100,
		OP_ORI = 6'b001101,
		OP_XORI = 6'b001110,
		OP_LUI = 6'b001111,
		OP_LB = 6'b100000,
		OP_LH = 6'b100001,
		OP_LW = 6'b100011,
		OP_LBU = 6'b100100,
		OP_LHU = 6'b100101,
		OP_LWU = 6'b100111,
		OP_SB = 6'b101000,
		OP_SH = 6'b101001,
		OP_SW = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL = 6'b000000,
		FN_SRL = 6'b000010,
		FN_SRA = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND = 6'b100100,
		FN_OR = 6'b100101,
		FN_XOR = 6'b100110,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// Operation class from the main decoder
	typedef enum logic [2:0] {
		ALUOP_RTYPE = 3'b000, // Look at funct
		ALUOP_ADD = 3'b001,
		ALUOP_AND = 3'b010,
		ALUOP_OR = 3'b011,
		ALUOP_XOR = 3'b100,
		ALUOP_SUB = 3'b101,
		ALUOP_SLT = 3'b110,
		ALUOP_LUI = 3'b111
	} aluop_e;

	// Function performed in execute
	typedef enum logic [3:0] {
		ALU_SLL = 4'd0,
		ALU_SRL = 4'd1,
		ALU_SRA = 4'd2,
		ALU_SLLV = 4'd3,
		ALU_SRLV = 4'd4,
		ALU_SRAV = 4'd5,
		ALU_ADD = 4'd6,
		ALU_SUB = 4'd7,
		ALU_AND = 4'd8,
		ALU_OR = 4'd9,
		ALU_XOR = 4'd10,
		ALU_NOR = 4'd11,
		ALU_SLT = 4'd12,
		ALU_SLTU = 4'd13,
		ALU_LUI = 4'd14
	} alu_code_e;

	////////////////////////////////////////
	// Control bundles and ID/EX register
	////////////////////////////////////////

	typedef struct packed {
		logic link; // Write PC+8
		logic link_only; // JAL, destination is the link register
		logic reg_dst; // Destination from rd
		logic alu_src1; // Shamt as operand A
		logic alu_src2; // Immediate as operand B
		logic jump;
		logic jump_reg;
		alu_code_e alu_code;
	} exec_ctrl_t;

	typedef struct packed {
		logic branch_ne;
		logic store_byte;
		logic store_half;
		logic load_byte;
		logic load_half;
		logic load_unsigned;
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		logic valid;
		logic [`MIPS_XLEN-1:0] pc;
		logic [`MIPS_XLEN-1:0] rs_data;
		logic [`MIPS_XLEN-1:0] rt_data;
		logic [`MIPS_XLEN-1:0] imm; // Already extended
		logic [4:0] shamt;
		logic [`MIPS_REG_AW-1:0] dest;
		exec_ctrl_t exec;
		mem_ctrl_t mem;
		wb_ctrl_t wb;
	} id_ex_t;

endpackage

// ==== rtl/alu_control.sv ====
`timescale 1ns/1ns

module alu_control import mips_pkg::*;
(
	input aluop_e aluop,
	input funct_e funct,
	output alu_code_e alu_code
);

	always_comb
	begin
		case (aluop)
			ALUOP_RTYPE:
			begin
				case (funct)
					FN_SLL: alu_code = ALU_SLL;
					FN_SRL: alu_code = ALU_SRL;
					FN_SRA: alu_code = ALU_SRA;
					FN_SLLV: alu_code = ALU_SLLV;
					FN_SRLV: alu_code = ALU_SRLV;
					FN_SRAV: alu_code = ALU_SRAV;
					FN_ADDU: alu_code = ALU_ADD;
					FN_SUBU: alu_code = ALU_SUB;
					FN_AND: alu_code = ALU_AND;
					FN_OR: alu_code = ALU_OR;
					FN_XOR: alu_code = ALU_XOR;
					FN_NOR: alu_code = ALU_NOR;
					FN_SLT: alu_code = ALU_SLT;
					FN_SLTU: alu_code = ALU_SLTU;
					// JR and JALR pass rs through an add, as does anything unknown
					default: alu_code = ALU_ADD;
				endcase
			end
			ALUOP_ADD: alu_code = ALU_ADD;
			ALUOP_AND: alu_code = ALU_AND;
			ALUOP_OR: alu_code = ALU_OR;
			ALUOP_XOR: alu_code = ALU_XOR;
			ALUOP_SUB: alu_code = ALU_SUB; // Branch compare
			ALUOP_SLT: alu_code = ALU_SLT;
			ALUOP_LUI: alu_code = ALU_LUI;
			default: alu_code = ALU_ADD;
		endcase
	end

endmodule

// ==== rtl/control.sv ====
`timescale 1ns/1ns

module control import mips_pkg::*;
(
	input logic kill,
	input opcode_e opcode,
	input funct_e funct,
	output exec_ctrl_t exec,
	output mem_ctrl_t mem,
	output wb_ctrl_t wb
);

	aluop_e aluop;
	alu_code_e alu_code;
	logic listed; // Opcode and funct both known

	alu_control u_alu_control
	(
		.aluop(aluop),
		.funct(funct),
		.alu_code(alu_code)
	);

	////////////////////////////////////////
	// Main decode
	////////////////////////////////////////

	always_comb
	begin
		exec = '0;
		mem = '0;
		wb = '0;
		aluop = ALUOP_RTYPE;
		listed = 1'b1;

		case (opcode)
			OP_SPECIAL:
			begin
				case (funct)
					FN_SLL, FN_SRL, FN_SRA:
					begin
						// Shift amount comes from the instruction
						exec.alu_src1 = 1'b1;
						exec.reg_dst = 1'b1;
						wb.reg_write = 1'b1;
					end
					FN_JR:
					begin
						exec.jump_reg = 1'b1;
					end
					FN_JALR:
					begin
						exec.link = 1'b1;
						exec.reg_dst = 1'b1;
						exec.jump_reg = 1'b1;
						wb.reg_write = 1'b1;
					end
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
					begin
						exec.reg_dst = 1'b1;
						wb.reg_write = 1'b1;
					end
					default:
					begin
						listed = 1'b0;
					end
				endcase
			end

			// Loads, LW and LWU both full word
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
			begin
				exec.alu_src2 = 1'b1;
				mem.mem_read = 1'b1;
				mem.load_byte = (opcode == OP_LB) || (opcode == OP_LBU);
				mem.load_half = (opcode == OP_LH) || (opcode == OP_LHU);
				mem.load_unsigned = (opcode == OP_LBU) || (opcode == OP_LHU);
				wb.reg_write = 1'b1;
				wb.mem_to_reg = 1'b1;
				aluop = ALUOP_ADD; // Base plus offset
			end

			// Stores
			OP_SB, OP_SH, OP_SW:
			begin
				exec.alu_src2 = 1'b1;
				mem.mem_write = 1'b1;
				mem.store_byte = (opcode == OP_SB);
				mem.store_half = (opcode == OP_SH);
				aluop = ALUOP_ADD;
			end

			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI:
			begin
				exec.alu_src2 = 1'b1;
				wb.reg_write = 1'b1;
				case (opcode)
					OP_ANDI: aluop = ALUOP_AND;
					OP_ORI: aluop = ALUOP_OR;
					OP_XORI: aluop = ALUOP_XOR;
					OP_LUI: aluop = ALUOP_LUI;
					OP_SLTI: aluop = ALUOP_SLT;
					default: aluop = ALUOP_ADD;
				endcase
			end

			OP_BEQ, OP_BNE:
			begin
				mem.branch = 1'b1;
				mem.branch_ne = (opcode == OP_BNE);
				aluop = ALUOP_SUB;
			end

			OP_J:
			begin
				exec.jump = 1'b1;
				aluop = ALUOP_ADD;
			end

			OP_JAL:
			begin
				exec.link = 1'b1;
				exec.link_only = 1'b1;
				exec.jump = 1'b1;
				wb.reg_write = 1'b1;
				aluop = ALUOP_ADD;
			end

			default:
			begin
				listed = 1'b0; // Nop
			end
		endcase

		if (listed)
			exec.alu_code = alu_code;

		// Bubble, reset or nothing valid upstream
		if (kill)
		begin
			exec = '0;
			mem = '0;
			wb = '0;
		end
	end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns

`include "mips_settings.svh"

module register_file
(
	input logic clk,
	input logic [`MIPS_REG_AW-1:0] rs_addr,
	input logic [`MIPS_REG_AW-1:0] rt_addr,
	input logic [`MIPS_REG_AW-1:0] wr_addr,
	input logic wr_en,
	input logic [`MIPS_XLEN-1:0] wr_data,
	output logic [`MIPS_XLEN-1:0] rs_data,
	output logic [`MIPS_XLEN-1:0] rt_data
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	// Register zero never gets written
	always_ff @(posedge clk)
	begin
		if (wr_en && (wr_addr != '0))
			regs[wr_addr] <= wr_data;
	end

	// One read port with write-through bypass
	function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
		logic [`MIPS_XLEN-1:0] value;
		if (addr == '0)
			value = '0; // Hard-wired zero
		else if (wr_en && (wr_addr == addr))
			value = wr_data; // Same-cycle write wins
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns

`include "mips_settings.svh"

module decode_stage import mips_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic stall,
	input logic flush,
	input logic [`MIPS_XLEN-1:0] instr,
	input logic [`MIPS_XLEN-1:0] pc,
	input logic wb_write,
	input logic [`MIPS_REG_AW-1:0] wb_addr,
	input logic [`MIPS_XLEN-1:0] wb_data,
	output id_ex_t id_ex
);

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////

	opcode_e opcode;
	funct_e funct;
	logic [`MIPS_REG_AW-1:0] rs;
	logic [`MIPS_REG_AW-1:0] rt;
	logic [`MIPS_REG_AW-1:0] rd;
	logic [4:0] shamt;
	logic [15:0] imm16;

	assign opcode = opcode_e'(instr[31:26]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = funct_e'(instr[5:0]);
	assign imm16 = instr[15:0];

	logic kill;
	exec_ctrl_t ctrl_exec;
	mem_ctrl_t ctrl_mem;
	wb_ctrl_t ctrl_wb;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	logic zero_ext;
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_REG_AW-1:0] dest;
	id_ex_t id_ex_d;

	// Any reason not to issue this cycle
	assign kill = reset || flush || stall || !instr_valid;

	control u_control
	(
		.kill(kill),
		.opcode(opcode),
		.funct(funct),
		.exec(ctrl_exec),
		.mem(ctrl_mem),
		.wb(ctrl_wb)
	);

	register_file u_register_file
	(
		.clk(clk),
		.rs_addr(rs),
		.rt_addr(rt),
		.wr_addr(wb_addr),
		.wr_en(wb_write),
		.wr_data(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	// Logical immediates are unsigned
	assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
	assign imm_ext = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm16}
		: {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

	always_comb
	begin
		if (ctrl_exec.reg_dst)
			dest = rd;
		else if (ctrl_exec.link_only)
			dest = `MIPS_REG_AW'(`MIPS_LINK_REG); // JAL
		else
			dest = rt;
	end

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	always_comb
	begin
		id_ex_d.valid = !kill;
		id_ex_d.pc = pc;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.imm = imm_ext;
		id_ex_d.shamt = shamt;
		id_ex_d.dest = dest;
		id_ex_d.exec = ctrl_exec;
		id_ex_d.mem = ctrl_mem;
		id_ex_d.wb = ctrl_wb;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			id_ex <= '0;
		else
			id_ex <= id_ex_d;
	end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock
#(
	parameter int PERIOD = 20 // ns
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ns

`include "mips_settings.svh"

module tb_decode_stage import mips_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic reset;
	logic instr_valid;
	logic stall;
	logic flush;
	logic [`MIPS_XLEN-1:0] instr;
	logic [`MIPS_XLEN-1:0] pc;
	logic wb_write;
	logic [`MIPS_REG_AW-1:0] wb_addr;
	logic [`MIPS_XLEN-1:0] wb_data;
	id_ex_t id_ex;

	logic [`MIPS_XLEN-1:0] reg_model [`MIPS_NREGS]; // Expected register contents
	logic [31:0] rng_state;
	int cycle_count;

	tb_clock u_tb_clock
	(
		.clk(clk)
	);

	decode_stage u_decode_stage
	(
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.stall(stall),
		.flush(flush),
		.instr(instr),
		.pc(pc),
		.wb_write(wb_write),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.id_ex(id_ex)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// MIPS instruction formats
	function automatic logic [31:0] r_format(input funct_e fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'b000000, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_format(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	function automatic logic [31:0] j_format(input opcode_e op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic check_bundles(input string name, input logic exp_valid,
		input exec_ctrl_t exp_exec, input mem_ctrl_t exp_mem, input wb_ctrl_t exp_wb);
		check_value({name, " valid"}, exp_valid, id_ex.valid);
		check_value({name, " exec"}, exp_exec, id_ex.exec);
		check_value({name, " mem"}, exp_mem, id_ex.mem);
		check_value({name, " wb"}, exp_wb, id_ex.wb);
	endtask

	// Called at a falling edge and returns one cycle later with id_ex loaded
	task automatic drive_instr(input logic [31:0] word, input logic [31:0] addr,
		input logic valid_lvl, input logic stall_lvl, input logic flush_lvl);
		instr = word;
		pc = addr;
		instr_valid = valid_lvl;
		stall = stall_lvl;
		flush = flush_lvl;
		@(negedge clk);
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		instr_valid = 1'b0;
		wb_write = 1'b1;
		wb_addr = addr;
		wb_data = data;
		@(negedge clk);
		wb_write = 1'b0;
		if (addr != 5'd0)
			reg_model[addr] = data; // Writes to r0 are dropped
	endtask

	task automatic run_immediate(input string name, input opcode_e op, input logic [15:0] imm16,
		input logic [31:0] exp_imm, input alu_code_e exp_code);
		exec_ctrl_t e;
		wb_ctrl_t w;
		e = '0;
		e.alu_src2 = 1'b1;
		e.alu_code = exp_code;
		w = '0;
		w.reg_write = 1'b1;
		drive_instr(i_format(op, 5'd11, 5'd14, imm16), 32'h0040_0100, 1'b1, 1'b0, 1'b0);
		check_bundles(name, 1'b1, e, '0, w);
		check_value({name, " imm"}, exp_imm, id_ex.imm);
		check_value({name, " dest"}, 14, id_ex.dest);
		check_value({name, " rs_data"}, reg_model[11], id_ex.rs_data);
	endtask

	task automatic run_memory(input string name, input opcode_e op, input logic is_load,
		input logic byte_w, input logic half_w, input logic unsigned_ld);
		exec_ctrl_t e;
		mem_ctrl_t m;
		wb_ctrl_t w;
		e = '0;
		e.alu_src2 = 1'b1;
		e.alu_code = ALU_ADD; // Base plus offset
		m = '0;
		m.mem_read = is_load;
		m.mem_write = !is_load;
		m.load_byte = is_load && byte_w;
		m.load_half = is_load && half_w;
		m.load_unsigned = is_load && unsigned_ld;
		m.store_byte = !is_load && byte_w;
		m.store_half = !is_load && half_w;
		w.reg_write = is_load;
		w.mem_to_reg = is_load;
		drive_instr(i_format(op, 5'd29, 5'd8, 16'hFFFC), 32'h0040_0200, 1'b1, 1'b0, 1'b0);
		check_bundles(name, 1'b1, e, m, w);
		check_value({name, " imm"}, 32'hFFFF_FFFC, id_ex.imm);
		check_value({name, " rs_data"}, reg_model[29], id_ex.rs_data);
		check_value({name, " rt_data"}, reg_model[8], id_ex.rt_data);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_after_reset();
		check_bundles("reset", 1'b0, '0, '0, '0);
	endtask

	task automatic test_rtype();
		exec_ctrl_t e;
		wb_ctrl_t w;
		logic [31:0] fresh;
		for (int i = 0; i < `MIPS_NREGS; i++)
			write_reg(i[4:0], next_random()); // The r0 write must not stick
		w = '0;
		w.reg_write = 1'b1;

		drive_instr(r_format(FN_ADDU, 5'd3, 5'd7, 5'd12, 5'd0), 32'h0040_0010, 1'b1, 1'b0, 1'b0);
		e = '0;
		e.reg_dst = 1'b1;
		e.alu_code = ALU_ADD;
		check_bundles("ADDU", 1'b1, e, '0, w);
		check_value("ADDU rs_data", reg_model[3], id_ex.rs_data);
		check_value("ADDU rt_data", reg_model[7], id_ex.rt_data);
		check_value("ADDU dest", 12, id_ex.dest);
		check_value("ADDU pc", 32'h0040_0010, id_ex.pc);

		drive_instr(r_format(FN_SUBU, 5'd0, 5'd31, 5'd1, 5'd0), 32'h0040_0014, 1'b1, 1'b0, 1'b0);
		e.alu_code = ALU_SUB;
		check_bundles("SUBU", 1'b1, e, '0, w);
		check_value("SUBU rs_data", 0, id_ex.rs_data); // r0 operand
		check_value("SUBU rt_data", reg_model[31], id_ex.rt_data);
		check_value("SUBU dest", 1, id_ex.dest);

		drive_instr(r_format(FN_SLL, 5'd0, 5'd9, 5'd4, 5'd13), 32'h0040_0018, 1'b1, 1'b0, 1'b0);
		e.alu_src1 = 1'b1;
		e.alu_code = ALU_SLL;
		check_bundles("SLL", 1'b1, e, '0, w);
		check_value("SLL shamt", 13, id_ex.shamt);
		check_value("SLL rt_data", reg_model[9], id_ex.rt_data);
		check_value("SLL dest", 4, id_ex.dest);

		drive_instr(r_format(FN_NOR, 5'd30, 5'd2, 5'd17, 5'd0), 32'h0040_001C, 1'b1, 1'b0, 1'b0);
		e = '0;
		e.reg_dst = 1'b1;
		e.alu_code = ALU_NOR;
		check_bundles("NOR", 1'b1, e, '0, w);
		check_value("NOR rs_data", reg_model[30], id_ex.rs_data);
		check_value("NOR dest", 17, id_ex.dest);

		// Write r20 in the same cycle that it is read
		fresh = next_random();
		wb_write = 1'b1;
		wb_addr = 5'd20;
		wb_data = fresh;
		drive_instr(r_format(FN_ADDU, 5'd20, 5'd0, 5'd5, 5'd0), 32'h0040_0020, 1'b1, 1'b0, 1'b0);
		wb_write = 1'b0;
		reg_model[20] = fresh;
		check_value("write-through rs_data", fresh, id_ex.rs_data);
		drive_instr(r_format(FN_ADDU, 5'd20, 5'd0, 5'd5, 5'd0), 32'h0040_0024, 1'b1, 1'b0, 1'b0);
		check_value("stored rs_data", fresh, id_ex.rs_data);
	endtask

	task automatic test_immediates();
		run_immediate("ADDI", OP_ADDI, 16'hFF85, 32'hFFFF_FF85, ALU_ADD);
		run_immediate("ANDI", OP_ANDI, 16'h8F0F, 32'h0000_8F0F, ALU_AND);
		run_immediate("ORI", OP_ORI, 16'hF000, 32'h0000_F000, ALU_OR);
		run_immediate("XORI", OP_XORI, 16'hFFFF, 32'h0000_FFFF, ALU_XOR);
		run_immediate("LUI", OP_LUI, 16'h8001, 32'hFFFF_8001, ALU_LUI);
		run_immediate("SLTI", OP_SLTI, 16'h8000, 32'hFFFF_8000, ALU_SLT);
	endtask

	task automatic test_memory();
		run_memory("LB", OP_LB, 1'b1, 1'b1, 1'b0, 1'b0);
		run_memory("LH", OP_LH, 1'b1, 1'b0, 1'b1, 1'b0);
		run_memory("LW", OP_LW, 1'b1, 1'b0, 1'b0, 1'b0);
		run_memory("LBU", OP_LBU, 1'b1, 1'b1, 1'b0, 1'b1);
		run_memory("LHU", OP_LHU, 1'b1, 1'b0, 1'b1, 1'b1);
		run_memory("LWU", OP_LWU, 1'b1, 1'b0, 1'b0, 1'b0); // Full word without the unsigned flag
		run_memory("SB", OP_SB, 1'b0, 1'b1, 1'b0, 1'b0);
		run_memory("SH", OP_SH, 1'b0, 1'b0, 1'b1, 1'b0);
		run_memory("SW", OP_SW, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_control_flow();
		exec_ctrl_t e;
		mem_ctrl_t m;
		wb_ctrl_t w;
		e = '0;
		m = '0;
		w = '0;
		e.alu_code = ALU_SUB; // Branch compare
		m.branch = 1'b1;
		drive_instr(i_format(OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h0040_0300, 1'b1, 1'b0, 1'b0);
		check_bundles("BEQ", 1'b1, e, m, w);
		m.branch_ne = 1'b1;
		drive_instr(i_format(OP_BNE, 5'd1, 5'd2, 16'hFFF0), 32'h0040_0304, 1'b1, 1'b0, 1'b0);
		check_bundles("BNE", 1'b1, e, m, w);

		e = '0;
		m = '0;
		e.jump = 1'b1;
		e.alu_code = ALU_ADD;
		drive_instr(j_format(OP_J, 26'h010_0040), 32'h0040_0308, 1'b1, 1'b0, 1'b0);
		check_bundles("J", 1'b1, e, m, w);

		e.link = 1'b1;
		e.link_only = 1'b1;
		w.reg_write = 1'b1;
		drive_instr(j_format(OP_JAL, 26'h010_0080), 32'h0040_030C, 1'b1, 1'b0, 1'b0);
		check_bundles("JAL", 1'b1, e, m, w);
		check_value("JAL dest", `MIPS_LINK_REG, id_ex.dest);

		e = '0;
		w = '0;
		e.jump_reg = 1'b1;
		e.alu_code = ALU_ADD;
		drive_instr(r_format(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0), 32'h0040_0310, 1'b1, 1'b0, 1'b0);
		check_bundles("JR", 1'b1, e, m, w);
		check_value("JR rs_data", reg_model[31], id_ex.rs_data);

		e.link = 1'b1;
		e.reg_dst = 1'b1;
		w.reg_write = 1'b1;
		drive_instr(r_format(FN_JALR, 5'd6, 5'd0, 5'd25, 5'd0), 32'h0040_0314, 1'b1, 1'b0, 1'b0);
		check_bundles("JALR", 1'b1, e, m, w);
		check_value("JALR dest", 25, id_ex.dest);
	endtask

	task automatic test_bubbles();
		logic [31:0] word;
		word = r_format(FN_ADDU, 5'd3, 5'd7, 5'd12, 5'd0);
		drive_instr(word, 32'h0040_0400, 1'b1, 1'b1, 1'b0);
		check_bundles("stall", 1'b0, '0, '0, '0);
		drive_instr(word, 32'h0040_0400, 1'b1, 1'b0, 1'b1);
		check_bundles("flush", 1'b0, '0, '0, '0);
		drive_instr(word, 32'h0040_0400, 1'b0, 1'b0, 1'b0);
		check_bundles("instr_valid low", 1'b0, '0, '0, '0);

		// Unknown encodings decode as nops but stay valid
		drive_instr({6'b111111, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU}, 32'h0040_0404,
			1'b1, 1'b0, 1'b0);
		check_bundles("unlisted opcode", 1'b1, '0, '0, '0);
		drive_instr(r_format(funct_e'(6'b111111), 5'd1, 5'd2, 5'd3, 5'd0), 32'h0040_0408,
			1'b1, 1'b0, 1'b0);
		check_bundles("unlisted funct", 1'b1, '0, '0, '0);
	endtask

	////////////////////////////////////////
	// Run
	////////////////////////////////////////

	initial
	begin
		rng_state = 32'd74;
		reset = 1'b1;
		instr_valid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		instr = '0;
		pc = '0;
		wb_write = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		reg_model[0] = '0;

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_after_reset();
		test_rtype();
		test_immediates();
		test_memory();
		test_control_flow();
		test_bubbles();

		$display("Finished with no errors");
		$finish;
	end

	// Watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Finished with errors");
		$fatal(1, "Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/alu_control.sv
rtl/control.sv
rtl/register_file.sv
rtl/decode_stage.sv
sim/tb_clock.sv
sim/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: mips_decode_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/alu_control.sv
      - rtl/control.sv
      - rtl/register_file.sv
      - rtl/decode_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clock.sv
      - sim/tb_decode_stage.sv
